// File: rx_dsp_pkg.sv
package rx_dsp_pkg;

    // Sample and coefficient widths
    localparam int code_w     = 8;
    localparam int weight_w   = 8;
    localparam int ffe_out_w  = 10;
    localparam int tap_w      = 8;
    localparam int est_code_w = 10;
    localparam int error_w    = 11;
    localparam int shift_w    = 4;

    // Largest filters the coefficient arrays can hold
    localparam int max_ffe_len  = 8;
    localparam int max_chan_len = 4;

    // Full-precision sums for the largest filters
    localparam int ffe_acc_w  = code_w + weight_w + $clog2(max_ffe_len);
    localparam int chan_acc_w = tap_w + 1 + $clog2(max_chan_len);

    typedef logic signed [code_w-1:0]     code_t;
    typedef logic signed [weight_w-1:0]   weight_t;
    typedef logic signed [ffe_out_w-1:0]  ffe_out_t;
    typedef logic signed [tap_w-1:0]      tap_t;
    typedef logic signed [est_code_w-1:0] est_code_t;
    typedef logic signed [error_w-1:0]    error_t;
    typedef logic        [shift_w-1:0]    shift_t;

    typedef logic signed [ffe_acc_w-1:0]  ffe_acc_t;
    typedef logic signed [chan_acc_w-1:0] chan_acc_t;

    // Saturation limits
    localparam ffe_out_t ffe_out_max = {1'b0, {(ffe_out_w-1){1'b1}}};
    localparam ffe_out_t ffe_out_min = {1'b1, {(ffe_out_w-1){1'b0}}};

    localparam est_code_t est_code_max = {1'b0, {(est_code_w-1){1'b1}}};
    localparam est_code_t est_code_min = {1'b1, {(est_code_w-1){1'b0}}};

endpackage

// File: rx_cfg_pkg.sv
package rx_cfg_pkg;

    localparam int cfg_sel_w  = 3;
    localparam int cfg_idx_w  = 3;
    localparam int cfg_data_w = 16;
    localparam int ffe_mode_w = 1;

    // Register write opcodes
    typedef enum logic [cfg_sel_w-1:0] {
        CFG_FFE_WEIGHT = 3'd0,
        CFG_FFE_SHIFT  = 3'd1,
        CFG_THRESH     = 3'd2,
        CFG_CHAN_TAP   = 3'd3,
        CFG_CHAN_SHIFT = 3'd4,
        CFG_MODE       = 3'd5
    } cfg_reg_e;

    typedef enum logic [ffe_mode_w-1:0] {
        FFE_FILTER = 1'b0,
        FFE_BYPASS = 1'b1
    } ffe_mode_e;

    // Tap index within the weight or channel array
    typedef logic [cfg_idx_w-1:0]  cfg_idx_t;
    typedef logic [cfg_data_w-1:0] cfg_data_t;

endpackage

// File: rx_cfg_if.sv
`timescale 1ns/100ps

interface rx_cfg_if #(
    parameter int ffe_len  = 4,
    parameter int chan_len = 3
);
    import rx_dsp_pkg::*;
    import rx_cfg_pkg::*;

    // FFE and slicer settings
    weight_t [ffe_len-1:0] weights;
    shift_t                ffe_shift;
    ffe_out_t              thresh;
    ffe_mode_e             mode;

    // Channel estimate settings
    tap_t [chan_len-1:0] chan_taps;
    shift_t              chan_shift;

    modport regs (output weights, ffe_shift, thresh, chan_taps, chan_shift, mode);
    modport lane (input weights, ffe_shift, thresh, mode);
    modport est  (input chan_taps, chan_shift);

    if (ffe_len > max_ffe_len) begin : g_ffe_len_chk
        $error("ffe_len exceeds max_ffe_len");
    end

    if (chan_len > max_chan_len) begin : g_chan_len_chk
        $error("chan_len exceeds max_chan_len");
    end

endinterface

// File: rx_cfg_regs.sv
`timescale 1ns/100ps

module rx_cfg_regs #(
    parameter int ffe_len  = 4,
    parameter int chan_len = 3
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  cfg_we_i,
    input  rx_cfg_pkg::cfg_reg_e  cfg_sel_i,
    input  rx_cfg_pkg::cfg_idx_t  cfg_idx_i,
    input  rx_cfg_pkg::cfg_data_t cfg_data_i,
    rx_cfg_if.regs                cfg
);
    import rx_dsp_pkg::*;
    import rx_cfg_pkg::*;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg.weights    <= '0;
            cfg.ffe_shift  <= '0;
            cfg.thresh     <= '0;
            cfg.chan_taps  <= '0;
            cfg.chan_shift <= '0;
            cfg.mode       <= FFE_FILTER;
        end else if (cfg_we_i) begin
            case (cfg_sel_i)
                CFG_FFE_WEIGHT: begin
                    // Only indices inside the array match
                    for (int i = 0; i < ffe_len; i++) begin
                        if (cfg_idx_i == cfg_idx_t'(i)) begin
                            cfg.weights[i] <= weight_t'(cfg_data_i[weight_w-1:0]);
                        end
                    end
                end
                CFG_FFE_SHIFT: begin
                    cfg.ffe_shift <= shift_t'(cfg_data_i[shift_w-1:0]);
                end
                CFG_THRESH: begin
                    cfg.thresh <= ffe_out_t'(cfg_data_i[ffe_out_w-1:0]);
                end
                CFG_CHAN_TAP: begin
                    for (int i = 0; i < chan_len; i++) begin
                        if (cfg_idx_i == cfg_idx_t'(i)) begin
                            cfg.chan_taps[i] <= tap_t'(cfg_data_i[tap_w-1:0]);
                        end
                    end
                end
                CFG_CHAN_SHIFT: begin
                    cfg.chan_shift <= shift_t'(cfg_data_i[shift_w-1:0]);
                end
                CFG_MODE: begin
                    cfg.mode <= ffe_mode_e'(cfg_data_i[ffe_mode_w-1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // Writes carry one of the defined opcodes
    a_cfg_sel_defined: assert property (@(posedge clk) disable iff (!rst_n_i)
        cfg_we_i |-> cfg_sel_i inside {CFG_FFE_WEIGHT, CFG_FFE_SHIFT, CFG_THRESH,
                                       CFG_CHAN_TAP, CFG_CHAN_SHIFT, CFG_MODE});

endmodule

// File: code_window_buffer.sv
`timescale 1ns/100ps

module code_window_buffer #(
    parameter int num_lanes = 8,
    parameter int ffe_len   = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rx_dsp_pkg::code_t adc_codes_i [num_lanes],
    output rx_dsp_pkg::code_t window_o    [num_lanes][ffe_len],
    output rx_dsp_pkg::code_t codes_dly_o [num_lanes]
);
    import rx_dsp_pkg::*;

    code_t cur_q  [num_lanes];
    code_t prev_q [num_lanes];

    // Previous word followed by current word, oldest sample first
    code_t span [2*num_lanes];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_q  <= '{default: '0};
            prev_q <= '{default: '0};
        end else begin
            cur_q  <= adc_codes_i;
            prev_q <= cur_q;
        end
    end

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            span[i]             = prev_q[i];
            span[num_lanes + i] = cur_q[i];
        end
        // Tap j of lane l sees sample n-j
        for (int l = 0; l < num_lanes; l++) begin
            for (int j = 0; j < ffe_len; j++) begin
                window_o[l][j] = span[num_lanes + l - j];
            end
        end
    end

    // Previous word doubles as the code delay that lines up with the bits
    assign codes_dly_o = prev_q;

    if (ffe_len > num_lanes + 1) begin : g_len_chk
        $error("ffe_len reaches past the previous word");
    end

endmodule

// File: ffe_slicer_lane.sv
`timescale 1ns/100ps

module ffe_slicer_lane #(
    parameter int ffe_len = 4
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rx_dsp_pkg::code_t      window_i [ffe_len],
    rx_cfg_if.lane                 cfg,
    output rx_dsp_pkg::ffe_out_t   ffe_o,
    output logic                   bit_o
);
    import rx_dsp_pkg::*;
    import rx_cfg_pkg::*;

    localparam ffe_acc_t sat_hi = ffe_acc_t'(ffe_out_max);
    localparam ffe_acc_t sat_lo = ffe_acc_t'(ffe_out_min);

    ffe_acc_t prod [ffe_len];
    ffe_acc_t acc;
    ffe_acc_t acc_sh;
    ffe_out_t eq;
    logic     primed_q;

    // Multiply-accumulate at full precision
    always_comb begin
        acc = '0;
        for (int j = 0; j < ffe_len; j++) begin
            prod[j] = window_i[j] * cfg.weights[j];
            acc     = acc + prod[j];
        end
        acc_sh = acc >>> cfg.ffe_shift;
    end

    always_comb begin
        if (cfg.mode == FFE_BYPASS) begin
            eq = ffe_out_t'(window_i[0]);
        end else if (acc_sh > sat_hi) begin
            eq = ffe_out_max;
        end else if (acc_sh < sat_lo) begin
            eq = ffe_out_min;
        end else begin
            eq = ffe_out_t'(acc_sh);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            primed_q <= 1'b0;
            ffe_o    <= '0;
            bit_o    <= 1'b0;
        end else begin
            primed_q <= 1'b1;
            ffe_o    <= eq;
            // Word ahead of the stream slices as bit 0
            bit_o    <= primed_q && (eq >= cfg.thresh);
        end
    end

endmodule

// File: channel_error_estimator.sv
`timescale 1ns/100ps

module channel_error_estimator #(
    parameter int num_lanes = 8,
    parameter int chan_len  = 3
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [num_lanes-1:0] bits_i,
    input  rx_dsp_pkg::code_t    codes_dly_i [num_lanes],
    rx_cfg_if.est                cfg,
    output rx_dsp_pkg::error_t   error_o [num_lanes]
);
    import rx_dsp_pkg::*;

    localparam chan_acc_t est_hi = chan_acc_t'(est_code_max);
    localparam chan_acc_t est_lo = chan_acc_t'(est_code_min);

    logic [num_lanes-1:0]   prev_bits_q;
    logic [2*num_lanes-1:0] bit_span;

    chan_acc_t acc    [num_lanes];
    chan_acc_t acc_sh [num_lanes];
    est_code_t est    [num_lanes];
    error_t    err_d  [num_lanes];
    error_t    err_q  [num_lanes];
    logic      err_nz;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_bits_q <= '0;
        end else begin
            prev_bits_q <= bits_i;
        end
    end

    assign bit_span = {bits_i, prev_bits_q};

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            acc[l] = '0;
            // Bit 1 adds the tap, bit 0 subtracts it
            for (int j = 0; j < chan_len; j++) begin
                if (bit_span[num_lanes + l - j]) begin
                    acc[l] = acc[l] + chan_acc_t'(cfg.chan_taps[j]);
                end else begin
                    acc[l] = acc[l] - chan_acc_t'(cfg.chan_taps[j]);
                end
            end
            acc_sh[l] = acc[l] >>> cfg.chan_shift;

            if (acc_sh[l] > est_hi) begin
                est[l] = est_code_max;
            end else if (acc_sh[l] < est_lo) begin
                est[l] = est_code_min;
            end else begin
                est[l] = est_code_t'(acc_sh[l]);
            end

            // Full range of est minus code fits error_t
            err_d[l] = error_t'(est[l]) - error_t'(codes_dly_i[l]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= '{default: '0};
        end else begin
            err_q <= err_d;
        end
    end

    assign error_o = err_q;

    always_comb begin
        err_nz = 1'b0;
        for (int l = 0; l < num_lanes; l++) begin
            err_nz = err_nz | (err_q[l] != '0);
        end
    end

    // First error word after reset is built from cleared bits and taps
    a_err_clear_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |=> !err_nz);

    if (chan_len > num_lanes + 1) begin : g_len_chk
        $error("chan_len reaches past the previous word");
    end

endmodule

// File: rx_dsp_datapath.sv
`timescale 1ns/100ps

module rx_dsp_datapath #(
    parameter int num_lanes = 8,
    parameter int ffe_len   = 4,
    parameter int chan_len  = 3
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  rx_dsp_pkg::code_t     adc_codes_i [num_lanes],
    input  logic                  cfg_we_i,
    input  rx_cfg_pkg::cfg_reg_e  cfg_sel_i,
    input  rx_cfg_pkg::cfg_idx_t  cfg_idx_i,
    input  rx_cfg_pkg::cfg_data_t cfg_data_i,
    output rx_dsp_pkg::ffe_out_t  ffe_o [num_lanes],
    output logic [num_lanes-1:0]  bits_o,
    output rx_dsp_pkg::error_t    error_o [num_lanes]
);
    import rx_dsp_pkg::*;

    code_t window    [num_lanes][ffe_len];
    code_t codes_dly [num_lanes];

    rx_cfg_if #(
        .ffe_len  (ffe_len),
        .chan_len (chan_len)
    ) cfg_bus ();

    rx_cfg_regs #(
        .ffe_len  (ffe_len),
        .chan_len (chan_len)
    ) u_cfg_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_sel_i  (cfg_sel_i),
        .cfg_idx_i  (cfg_idx_i),
        .cfg_data_i (cfg_data_i),
        .cfg        (cfg_bus)
    );

    code_window_buffer #(
        .num_lanes (num_lanes),
        .ffe_len   (ffe_len)
    ) u_window_buf (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .adc_codes_i (adc_codes_i),
        .window_o    (window),
        .codes_dly_o (codes_dly)
    );

    // One equalizer and slicer per lane
    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        ffe_slicer_lane #(
            .ffe_len (ffe_len)
        ) u_lane (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .window_i (window[l]),
            .cfg      (cfg_bus),
            .ffe_o    (ffe_o[l]),
            .bit_o    (bits_o[l])
        );
    end

    channel_error_estimator #(
        .num_lanes (num_lanes),
        .chan_len  (chan_len)
    ) u_err_est (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bits_i      (bits_o),
        .codes_dly_i (codes_dly),
        .cfg         (cfg_bus),
        .error_o     (error_o)
    );

endmodule

// File: tb_rx_dsp_datapath.sv
`timescale 1ns/100ps

module tb_rx_dsp_datapath;
    import rx_dsp_pkg::*;
    import rx_cfg_pkg::*;

    localparam int num_lanes  = 8;
    localparam int ffe_len    = 4;
    localparam int chan_len   = 3;
    localparam int n_words    = 112;
    localparam int clk_period = 8;

    logic                 clk;
    logic                 rst_n_i;
    code_t                adc_codes_i [num_lanes];
    logic                 cfg_we_i;
    cfg_reg_e             cfg_sel_i;
    cfg_idx_t             cfg_idx_i;
    cfg_data_t            cfg_data_i;
    ffe_out_t             ffe_o [num_lanes];
    logic [num_lanes-1:0] bits_o;
    error_t               error_o [num_lanes];

    // Model copy of the coefficient registers
    weight_t   m_weights [ffe_len];
    shift_t    m_ffe_shift;
    ffe_out_t  m_thresh;
    ffe_mode_e m_mode;
    tap_t      m_taps [chan_len];
    shift_t    m_chan_shift;

    code_t    x_hist [n_words*num_lanes];
    logic     s_hist [n_words*num_lanes];
    ffe_out_t exp_ffe_q [$];
    logic     exp_bit_q [$];
    error_t   exp_err_q [$];

    int word_cnt;
    int edge_cnt;
    int ffe_errs;
    int bit_errs;
    int err_errs;

    rx_dsp_datapath #(
        .num_lanes (num_lanes),
        .ffe_len   (ffe_len),
        .chan_len  (chan_len)
    ) dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .adc_codes_i (adc_codes_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_idx_i   (cfg_idx_i),
        .cfg_data_i  (cfg_data_i),
        .ffe_o       (ffe_o),
        .bits_o      (bits_o),
        .error_o     (error_o)
    );

    always #(clk_period/2) clk = ~clk;

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    // Samples ahead of the stream are code 0 and bit 0
    function automatic int x_at(input int n);
        return (n < 0) ? 0 : int'(x_hist[n]);
    endfunction

    function automatic int sym_at(input int n);
        return (n >= 0 && s_hist[n]) ? 1 : -1;
    endfunction

    function automatic ffe_out_t ref_ffe(input int n);
        int acc;
        acc = 0;
        for (int j = 0; j < ffe_len; j++) begin
            acc += int'(m_weights[j]) * x_at(n - j);
        end
        if (m_mode == FFE_BYPASS) begin
            return ffe_out_t'(x_at(n));
        end
        return ffe_out_t'(clamp(acc >>> m_ffe_shift,
                                -(2**(ffe_out_w-1)), 2**(ffe_out_w-1)-1));
    endfunction

    function automatic error_t ref_err(input int n);
        int acc;
        int est;
        acc = 0;
        for (int j = 0; j < chan_len; j++) begin
            acc += int'(m_taps[j]) * sym_at(n - j);
        end
        est = clamp(acc >>> m_chan_shift, -(2**(est_code_w-1)), 2**(est_code_w-1)-1);
        return error_t'(clamp(est - x_at(n), -(2**(error_w-1)), 2**(error_w-1)-1));
    endfunction

    task automatic check_ffe(input int lane, input ffe_out_t got, input ffe_out_t exp);
        if (got !== exp) begin
            $display("MISMATCH ffe_o[%0d]: got 0x%h, expected 0x%h", lane, got, exp);
            ffe_errs++;
        end
    endtask

    task automatic check_bit(input int lane, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH bits_o[%0d]: got 0x%h, expected 0x%h", lane, got, exp);
            bit_errs++;
        end
    endtask

    task automatic check_error(input int lane, input error_t got, input error_t exp);
        if (got !== exp) begin
            $display("MISMATCH error_o[%0d]: got 0x%h, expected 0x%h", lane, got, exp);
            err_errs++;
        end
    endtask

    task automatic apply_write(input cfg_reg_e sel, input int idx, input cfg_data_t d);
        case (sel)
            CFG_FFE_WEIGHT: if (idx < ffe_len) m_weights[idx] = weight_t'(d[weight_w-1:0]);
            CFG_FFE_SHIFT:  m_ffe_shift = shift_t'(d[shift_w-1:0]);
            CFG_THRESH:     m_thresh = ffe_out_t'(d[ffe_out_w-1:0]);
            CFG_CHAN_TAP:   if (idx < chan_len) m_taps[idx] = tap_t'(d[tap_w-1:0]);
            CFG_CHAN_SHIFT: m_chan_shift = shift_t'(d[shift_w-1:0]);
            CFG_MODE:       m_mode = ffe_mode_e'(d[0]);
            default:        ;
        endcase
    endtask

    task automatic queue_errors(input int w);
        for (int l = 0; l < num_lanes; l++) begin
            exp_err_q.push_back(ref_err(w * num_lanes + l));
        end
    endtask

    task automatic drive_word(input logic we, input cfg_reg_e sel, input int idx, input int data);
        int       base;
        ffe_out_t eq;
        base       = word_cnt * num_lanes;
        cfg_we_i   = we;
        cfg_sel_i  = sel;
        cfg_idx_i  = cfg_idx_t'(idx);
        cfg_data_i = cfg_data_t'(data);
        if (we) begin
            apply_write(sel, idx, cfg_data_t'(data));
        end
        for (int l = 0; l < num_lanes; l++) begin
            x_hist[base + l] = code_t'($urandom);
            adc_codes_i[l]   = x_hist[base + l];
        end
        // Equalizer sees a write made together with its word
        for (int l = 0; l < num_lanes; l++) begin
            eq = ref_ffe(base + l);
            s_hist[base + l] = (eq >= m_thresh);
            exp_ffe_q.push_back(eq);
            exp_bit_q.push_back(s_hist[base + l]);
        end
        // Channel estimate trails by a word
        if (word_cnt > 0) begin
            queue_errors(word_cnt - 1);
        end
        word_cnt++;
    endtask

    task automatic next_word(input logic we, input cfg_reg_e sel, input int idx, input int data);
        @(posedge clk);
        #1;
        drive_word(we, sel, idx, data);
    endtask

    task automatic write_word(input cfg_reg_e sel, input int idx, input int data);
        next_word(1'b1, sel, idx, data);
    endtask

    task automatic plain_words(input int count);
        repeat (count) begin
            next_word(1'b0, CFG_FFE_WEIGHT, 0, 0);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n_i) begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    always @(negedge clk) begin
        for (int l = 0; l < num_lanes; l++) begin
            if (!rst_n_i || edge_cnt < 2) begin
                check_ffe(l, ffe_o[l], '0);
                check_bit(l, bits_o[l], 1'b0);
            end else if (exp_ffe_q.size() > 0) begin
                check_ffe(l, ffe_o[l], exp_ffe_q.pop_front());
                check_bit(l, bits_o[l], exp_bit_q.pop_front());
            end
            if (!rst_n_i || edge_cnt < 3) begin
                check_error(l, error_o[l], '0);
            end else if (exp_err_q.size() > 0) begin
                check_error(l, error_o[l], exp_err_q.pop_front());
            end
        end
    end

    initial begin
        #((n_words + 50) * clk_period);
        $display("Timeout: output stream did not drain within %0d cycles", n_words + 50);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int big;
        void'($urandom(79));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = CFG_FFE_WEIGHT;
        cfg_idx_i   = '0;
        cfg_data_i  = '0;
        adc_codes_i = '{default: '0};
        m_weights   = '{default: '0};
        m_taps      = '{default: '0};
        m_ffe_shift  = '0;
        m_chan_shift = '0;
        m_thresh     = '0;
        m_mode       = FFE_FILTER;
        word_cnt = 0;
        edge_cnt = 0;
        ffe_errs = 0;
        bit_errs = 0;
        err_errs = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        // Bypass, threshold at zero, random channel
        drive_word(1'b1, CFG_MODE, 0, int'(FFE_BYPASS));
        write_word(CFG_THRESH, 0, 0);
        for (int j = 0; j < chan_len; j++) begin
            write_word(CFG_CHAN_TAP, j, int'(tap_t'($urandom)));
        end
        write_word(CFG_CHAN_SHIFT, 0, $urandom_range(0, 2));
        plain_words(12);
        write_word(CFG_MODE, 0, int'(FFE_FILTER));
        for (int j = 0; j < ffe_len; j++) begin
            write_word(CFG_FFE_WEIGHT, j, int'($urandom_range(0, 63)) - 32);
        end
        write_word(CFG_FFE_SHIFT, 0, $urandom_range(2, 5));
        write_word(CFG_THRESH, 0, int'($urandom_range(0, 80)) - 40);
        plain_words(20);
        // Rewrites in the middle of the stream
        write_word(CFG_THRESH, 0, int'($urandom_range(0, 80)) - 40);
        plain_words(4);
        write_word(CFG_FFE_WEIGHT, 1, int'($urandom_range(0, 63)) - 32);
        plain_words(4);
        write_word(CFG_FFE_WEIGHT, 3, int'($urandom_range(0, 63)) - 32);
        for (int j = ffe_len; j < 8; j++) begin
            write_word(CFG_FFE_WEIGHT, j, 16'h7f7f);
        end
        for (int j = chan_len; j < 8; j++) begin
            write_word(CFG_CHAN_TAP, j, 16'h7f7f);
        end
        plain_words(4);
        // Large weights without shift drive the equalizer into saturation
        for (int j = 0; j < ffe_len; j++) begin
            big = $urandom_range(100, 127);
            write_word(CFG_FFE_WEIGHT, j, ($urandom_range(0, 1) == 1) ? -big : big);
        end
        write_word(CFG_FFE_SHIFT, 0, 0);
        plain_words(12);
        for (int j = 0; j < chan_len; j++) begin
            write_word(CFG_CHAN_TAP, j, int'(tap_t'($urandom)));
        end
        write_word(CFG_CHAN_SHIFT, 0, $urandom_range(0, 3));
        plain_words(n_words - word_cnt);
        @(posedge clk);
        #1;
        cfg_we_i    = 1'b0;
        adc_codes_i = '{default: '0};
        queue_errors(word_cnt - 1);
        while (exp_err_q.size() != 0) begin
            @(posedge clk);
        end
        $display("Errors: ffe_o %0d, bits_o %0d, error_o %0d", ffe_errs, bit_errs, err_errs);
        if (ffe_errs + bit_errs + err_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rx_dsp.f
rx_dsp_pkg.sv
rx_cfg_pkg.sv
rx_cfg_if.sv
rx_cfg_regs.sv
code_window_buffer.sv
ffe_slicer_lane.sv
channel_error_estimator.sv
rx_dsp_datapath.sv
tb_rx_dsp_datapath.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f rx_dsp.f \
    --top-module tb_rx_dsp_datapath -o tb_rx_dsp_datapath \
    && ./obj_dir/tb_rx_dsp_datapath > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Compile or simulation error"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result in log"; exit 1; }
echo "Simulation passed"
exit 0
